// File: verilog/cw_reg_pkg.sv
package cw_reg_pkg;

   // host register map, one address per register
   localparam logic [7:0] ADDR_EXTCLK     = 8'd38;  // clock source byte
   localparam logic [7:0] ADDR_TRIGSRC    = 8'd39;  // 2 bytes
   localparam logic [7:0] ADDR_TRIGMOD    = 8'd40;
   localparam logic [7:0] ADDR_IOROUTE    = 8'd55;  // 8 bytes
   localparam logic [7:0] ADDR_COMPONENTS = 8'd62;  // read only
   localparam logic [7:0] ADDR_SOFTPOWER  = 8'd63;  // 8 bytes

   localparam int BYTECNT_W = 7;   // byte index within a multi-byte register
   localparam int TRIGSRC_W = 16;  // aux, nrst, io1-4, mode[7:6], userio 0-7

   // trigsrc[7:6], how the enabled external sources are merged
   localparam logic [1:0] TRIG_OR   = 2'd0;
   localparam logic [1:0] TRIG_AND  = 2'd1;
   localparam logic [1:0] TRIG_NAND = 2'd2;

   // trigmod[2:0], source of the capture trigger
   localparam logic [2:0] TMOD_EDGE_EXT   = 3'd0;
   localparam logic [2:0] TMOD_ADVIO      = 3'd1;
   localparam logic [2:0] TMOD_SAD        = 3'd2;
   localparam logic [2:0] TMOD_DECODEDIO  = 3'd3;
   localparam logic [2:0] TMOD_TRACE      = 3'd4;
   localparam logic [2:0] TMOD_ADC        = 3'd5;
   localparam logic [2:0] TMOD_EDGE       = 3'd6;

   // ioroute bits that still drive logic
   localparam int IOR_AVRPROG    = 40;
   localparam int IOR_POWER_OFF  = 41;
   localparam int IOR_FAST_START = 42;  // 0 = slow start via PWM
   localparam int IOR_NRST_EN    = 48;
   localparam int IOR_NRST       = 49;
   localparam int IOR_PDID_EN    = 50;
   localparam int IOR_PDID       = 51;
   localparam int IOR_PDIC_EN    = 52;
   localparam int IOR_PDIC       = 53;

   localparam logic [7:0]           EXTCLK_RST  = 8'h03;
   localparam logic [TRIGSRC_W-1:0] TRIGSRC_RST = 16'h0020;  // io4 only, OR
   localparam logic [63:0]          IOROUTE_RST = 64'h0201;  // power on, slow start

   // soft-power word, cycles1 sits in byte 0
   typedef struct packed {
      logic [15:0] off_time2;  // off cycles per period, second phase
      logic [15:0] off_time1;  // off cycles per period, first phase
      logic [15:0] period;     // PWM period is period+1 cycles
      logic [7:0]  cycles2;    // periods using off_time2
      logic [7:0]  cycles1;    // periods using off_time1
   } softpower_fields_t;

   // host sees bytes, the sequencer sees fields
   typedef union packed {
      logic [7:0][7:0]   bytes;
      softpower_fields_t f;
   } softpower_ctrl_u;

   localparam softpower_fields_t SOFTPOWER_RST = '{
      off_time2: 16'd0,
      off_time1: 16'd1995,
      period:    16'd2000,
      cycles2:   8'd0,
      cycles1:   8'd35
   };

endpackage

// File: verilog/cw_reg_file.sv
`timescale 1ns/10ps

module cw_reg_file (
   input  logic                             clk_usb,
   input  logic                             reset,
   input  logic [7:0]                       reg_address_i,
   input  logic [cw_reg_pkg::BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]                       reg_datai_i,
   input  logic                             reg_write_i,
   input  logic                             reg_read_i,
   input  logic                             trace_exists_i,
   input  logic                             la_exists_i,
   output logic [7:0]                       reg_datao_o,
   output logic [cw_reg_pkg::TRIGSRC_W-1:0] trigsrc_o,
   output logic [2:0]                       trigmod_o,
   output cw_reg_pkg::softpower_ctrl_u      softpower_o,
   output logic                             power_off_req_o,
   output logic                             fast_start_o,
   output logic                             enable_avrprog_o,
   output logic                             enable_output_nrst_o,
   output logic                             output_nrst_o,
   output logic                             enable_output_pdid_o,
   output logic                             output_pdid_o,
   output logic                             enable_output_pdic_o,
   output logic                             output_pdic_o
);

   logic [7:0]                       extclk_q;   // no clock logic behind this one
   logic [cw_reg_pkg::TRIGSRC_W-1:0] trigsrc_q;
   logic [7:0]                       trigmod_q;  // only [2:0] used downstream
   logic [63:0]                      ioroute_q;
   cw_reg_pkg::softpower_ctrl_u      softpower_q;

   logic [2:0] lane;       // byte lane of a multi-byte register
   logic       lane_ok16;  // bytecnt falls inside trigsrc
   logic       lane_ok64;  // bytecnt falls inside an 8 byte register
   logic [7:0] components; // which optional blocks are built in

   assign lane       = reg_bytecnt_i[2:0];
   assign lane_ok16  = (reg_bytecnt_i < cw_reg_pkg::TRIGSRC_W / 8);
   assign lane_ok64  = (reg_bytecnt_i < 8);
   assign components = {6'd0, trace_exists_i, la_exists_i};

   // host writes, one byte per strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         extclk_q      <= cw_reg_pkg::EXTCLK_RST;
         trigsrc_q     <= cw_reg_pkg::TRIGSRC_RST;
         trigmod_q     <= {5'd0, cw_reg_pkg::TMOD_EDGE_EXT};
         ioroute_q     <= cw_reg_pkg::IOROUTE_RST;
         softpower_q.f <= cw_reg_pkg::SOFTPOWER_RST;
      end else if (reg_write_i) begin
         case (reg_address_i)
            cw_reg_pkg::ADDR_EXTCLK:  extclk_q  <= reg_datai_i;
            cw_reg_pkg::ADDR_TRIGMOD: trigmod_q <= reg_datai_i;
            cw_reg_pkg::ADDR_TRIGSRC: begin
               if (lane_ok16) begin
                  trigsrc_q[{lane[0], 3'b000} +: 8] <= reg_datai_i;
               end
            end
            cw_reg_pkg::ADDR_IOROUTE: begin
               if (lane_ok64) begin
                  ioroute_q[{lane, 3'b000} +: 8] <= reg_datai_i;
               end
            end
            cw_reg_pkg::ADDR_SOFTPOWER: begin
               if (lane_ok64) begin
                  softpower_q.bytes[lane] <= reg_datai_i;
               end
            end
            default: ;  // components is read only, rest unmapped
         endcase
      end
   end

   // read data is a level, valid while reg_read_i is high
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (reg_address_i)
            cw_reg_pkg::ADDR_EXTCLK:     reg_datao_o = extclk_q;
            cw_reg_pkg::ADDR_TRIGMOD:    reg_datao_o = trigmod_q;
            cw_reg_pkg::ADDR_COMPONENTS: reg_datao_o = components;
            cw_reg_pkg::ADDR_TRIGSRC:
               reg_datao_o = lane_ok16 ? trigsrc_q[{lane[0], 3'b000} +: 8] : 8'h00;
            cw_reg_pkg::ADDR_IOROUTE:
               reg_datao_o = lane_ok64 ? ioroute_q[{lane, 3'b000} +: 8] : 8'h00;
            cw_reg_pkg::ADDR_SOFTPOWER:
               reg_datao_o = lane_ok64 ? softpower_q.bytes[lane] : 8'h00;
            default:                     reg_datao_o = 8'h00;
         endcase
      end
   end

   assign trigsrc_o   = trigsrc_q;
   assign trigmod_o   = trigmod_q[2:0];
   assign softpower_o = softpower_q;

   // routing bits used by the kept outputs
   assign power_off_req_o      = ioroute_q[cw_reg_pkg::IOR_POWER_OFF];
   assign fast_start_o         = ioroute_q[cw_reg_pkg::IOR_FAST_START];
   assign enable_avrprog_o     = ioroute_q[cw_reg_pkg::IOR_AVRPROG];
   assign enable_output_nrst_o = ioroute_q[cw_reg_pkg::IOR_NRST_EN];
   assign output_nrst_o        = ioroute_q[cw_reg_pkg::IOR_NRST];
   assign enable_output_pdid_o = ioroute_q[cw_reg_pkg::IOR_PDID_EN];
   assign output_pdid_o        = ioroute_q[cw_reg_pkg::IOR_PDID];
   assign enable_output_pdic_o = ioroute_q[cw_reg_pkg::IOR_PDIC_EN];
   assign output_pdic_o        = ioroute_q[cw_reg_pkg::IOR_PDIC];

endmodule

// File: verilog/trigger_combine.sv
`timescale 1ns/10ps

module trigger_combine #(
   parameter int USERIO_W = 8
) (
   input  logic [cw_reg_pkg::TRIGSRC_W-1:0] trigsrc_i,
   input  logic [2:0]                       trigmod_i,
   input  logic                             trigger_aux_i,
   input  logic                             trigger_nrst_i,
   input  logic [3:0]                       trigger_io_i,
   input  logic [USERIO_W-1:0]              userio_d_i,
   input  logic                             trigger_advio_i,
   input  logic                             trigger_sad_i,
   input  logic                             trigger_decodedio_i,
   input  logic                             trigger_trace_i,
   input  logic                             trigger_adc_i,
   input  logic                             trigger_edge_i,
   output logic                             trigger_ext_o,
   output logic                             trigger_capture_o,
   output logic                             decodeio_active_o,
   output logic                             sad_active_o,
   output logic                             edge_trigger_active_o
);

   localparam int USERIO_LSB = 8;             // trigsrc bit masking userio_d_i[0]
   localparam int NSRC       = USERIO_W + 6;  // aux, nrst, io1-4, user io

   logic [NSRC-1:0] src;
   logic [NSRC-1:0] mask;
   logic            trig_or;
   logic            trig_and;

   // same bit order as trigsrc, with the mode bits squeezed out
   assign src      = {userio_d_i, trigger_io_i, trigger_nrst_i, trigger_aux_i};
   assign mask     = {trigsrc_i[USERIO_LSB +: USERIO_W], trigsrc_i[5:0]};
   assign trig_or  = |(src & mask);
   assign trig_and = &(src | ~mask);  // disabled sources count as high

   always_comb begin
      case (trigsrc_i[7:6])
         cw_reg_pkg::TRIG_OR:   trigger_ext_o = trig_or;
         cw_reg_pkg::TRIG_AND:  trigger_ext_o = trig_and;
         cw_reg_pkg::TRIG_NAND: trigger_ext_o = ~trig_and;
         default:               trigger_ext_o = 1'b0;  // reserved mode
      endcase
   end

   // capture trigger follows the selected module
   always_comb begin
      case (trigmod_i)
         cw_reg_pkg::TMOD_EDGE_EXT:  trigger_capture_o = trigger_ext_o;
         cw_reg_pkg::TMOD_ADVIO:     trigger_capture_o = trigger_advio_i;
         cw_reg_pkg::TMOD_SAD:       trigger_capture_o = trigger_sad_i;
         cw_reg_pkg::TMOD_DECODEDIO: trigger_capture_o = trigger_decodedio_i;
         cw_reg_pkg::TMOD_TRACE:     trigger_capture_o = trigger_trace_i;
         cw_reg_pkg::TMOD_ADC:       trigger_capture_o = trigger_adc_i;
         cw_reg_pkg::TMOD_EDGE:      trigger_capture_o = trigger_edge_i;
         default:                    trigger_capture_o = 1'b0;
      endcase
   end

   assign decodeio_active_o     = (trigmod_i == cw_reg_pkg::TMOD_DECODEDIO);
   assign sad_active_o          = (trigmod_i == cw_reg_pkg::TMOD_SAD);
   assign edge_trigger_active_o = (trigmod_i == cw_reg_pkg::TMOD_EDGE);

endmodule

// File: verilog/target_power_softstart.sv
`timescale 1ns/10ps

module target_power_softstart (
   input  logic                        clk_usb,
   input  logic                        reset,
   input  cw_reg_pkg::softpower_ctrl_u softpower_i,
   input  logic                        power_off_req_i,
   input  logic                        fast_start_i,
   output logic                        targetpower_off_o
);

   logic        req_prev_q;     // request one cycle ago, for edge detect
   logic        soft_on_q;      // PWM sequence running
   logic [15:0] phase_q;        // position inside the PWM period
   logic [8:0]  period_cnt_q;   // completed periods, up to cycles1+cycles2
   logic [15:0] off_time_q;     // off cycles for the current period

   logic        start;
   logic        period_end;
   logic        seq_done;
   logic [8:0]  total_periods;
   logic [8:0]  period_cnt_nxt;
   logic        pwm_off;

   assign start         = req_prev_q & ~power_off_req_i;  // power released
   assign period_end    = soft_on_q & (phase_q == softpower_i.f.period);
   assign total_periods = softpower_i.f.cycles1 + softpower_i.f.cycles2;
   assign seq_done      = period_end & (period_cnt_q + 9'd1 >= total_periods);

   // period count as it will be after this edge
   always_comb begin
      if (!soft_on_q) begin
         period_cnt_nxt = 9'd0;
      end else if (period_end) begin
         period_cnt_nxt = period_cnt_q + 9'd1;
      end else begin
         period_cnt_nxt = period_cnt_q;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         req_prev_q   <= 1'b0;
         soft_on_q    <= 1'b0;
         phase_q      <= 16'd0;
         period_cnt_q <= 9'd0;
      end else begin
         req_prev_q <= power_off_req_i;
         if (power_off_req_i) begin
            soft_on_q <= 1'b0;    // power off again aborts the ramp
         end else if (start) begin
            soft_on_q <= 1'b1;
         end else if (seq_done) begin
            soft_on_q <= 1'b0;    // ramp finished, stay on
         end
         if (!soft_on_q || phase_q == softpower_i.f.period) begin
            phase_q <= 16'd0;
         end else begin
            phase_q <= phase_q + 16'd1;
         end
         period_cnt_q <= period_cnt_nxt;
      end
   end

   // first cycles1 periods use off_time1, then off_time2
   always_ff @(posedge clk_usb) begin
      if (period_cnt_nxt < softpower_i.f.cycles1) begin
         off_time_q <= softpower_i.f.off_time1;
      end else begin
         off_time_q <= softpower_i.f.off_time2;
      end
   end

   assign pwm_off = (phase_q < off_time_q);  // off at the start of each period

   assign targetpower_off_o = (soft_on_q & ~fast_start_i) ? pwm_off : power_off_req_i;

endmodule

// File: verilog/cw_reg_top.sv
`timescale 1ns/10ps

module cw_reg_top #(
   parameter int USERIO_W = 8
) (
   input  logic                             clk_usb,
   input  logic                             reset,
   input  logic [7:0]                       reg_address_i,
   input  logic [cw_reg_pkg::BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [7:0]                       reg_datai_i,
   input  logic                             reg_write_i,
   input  logic                             reg_read_i,
   input  logic                             trigger_aux_i,
   input  logic                             trigger_nrst_i,
   input  logic [3:0]                       trigger_io_i,
   input  logic [USERIO_W-1:0]              userio_d_i,
   input  logic                             trigger_advio_i,
   input  logic                             trigger_sad_i,
   input  logic                             trigger_decodedio_i,
   input  logic                             trigger_trace_i,
   input  logic                             trigger_adc_i,
   input  logic                             trigger_edge_i,
   input  logic                             trace_exists_i,
   input  logic                             la_exists_i,
   output logic [7:0]                       reg_datao_o,
   output logic                             trigger_ext_o,
   output logic                             trigger_capture_o,
   output logic                             decodeio_active_o,
   output logic                             sad_active_o,
   output logic                             edge_trigger_active_o,
   output logic                             targetpower_off_o,
   output logic                             enable_avrprog_o,
   output logic                             enable_output_nrst_o,
   output logic                             output_nrst_o,
   output logic                             enable_output_pdid_o,
   output logic                             output_pdid_o,
   output logic                             enable_output_pdic_o,
   output logic                             output_pdic_o
);

   logic [cw_reg_pkg::TRIGSRC_W-1:0] trigsrc;
   logic [2:0]                       trigmod;
   cw_reg_pkg::softpower_ctrl_u      softpower;
   logic                             power_off_req;  // ioroute power-off bit
   logic                             fast_start;

   cw_reg_file u_reg_file (
      .clk_usb              (clk_usb),
      .reset                (reset),
      .reg_address_i        (reg_address_i),
      .reg_bytecnt_i        (reg_bytecnt_i),
      .reg_datai_i          (reg_datai_i),
      .reg_write_i          (reg_write_i),
      .reg_read_i           (reg_read_i),
      .trace_exists_i       (trace_exists_i),
      .la_exists_i          (la_exists_i),
      .reg_datao_o          (reg_datao_o),
      .trigsrc_o            (trigsrc),
      .trigmod_o            (trigmod),
      .softpower_o          (softpower),
      .power_off_req_o      (power_off_req),
      .fast_start_o         (fast_start),
      .enable_avrprog_o     (enable_avrprog_o),
      .enable_output_nrst_o (enable_output_nrst_o),
      .output_nrst_o        (output_nrst_o),
      .enable_output_pdid_o (enable_output_pdid_o),
      .output_pdid_o        (output_pdid_o),
      .enable_output_pdic_o (enable_output_pdic_o),
      .output_pdic_o        (output_pdic_o)
   );

   // purely combinational trigger path
   trigger_combine #(
      .USERIO_W (USERIO_W)
   ) u_trigger_combine (
      .trigsrc_i             (trigsrc),
      .trigmod_i             (trigmod),
      .trigger_aux_i         (trigger_aux_i),
      .trigger_nrst_i        (trigger_nrst_i),
      .trigger_io_i          (trigger_io_i),
      .userio_d_i            (userio_d_i),
      .trigger_advio_i       (trigger_advio_i),
      .trigger_sad_i         (trigger_sad_i),
      .trigger_decodedio_i   (trigger_decodedio_i),
      .trigger_trace_i       (trigger_trace_i),
      .trigger_adc_i         (trigger_adc_i),
      .trigger_edge_i        (trigger_edge_i),
      .trigger_ext_o         (trigger_ext_o),
      .trigger_capture_o     (trigger_capture_o),
      .decodeio_active_o     (decodeio_active_o),
      .sad_active_o          (sad_active_o),
      .edge_trigger_active_o (edge_trigger_active_o)
   );

   target_power_softstart u_power_softstart (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .softpower_i       (softpower),
      .power_off_req_i   (power_off_req),
      .fast_start_i      (fast_start),
      .targetpower_off_o (targetpower_off_o)
   );

endmodule

// File: dv/cw_reg_tb.sv
`timescale 1ns/10ps

module cw_reg_tb;

   localparam int USERIO_W = 8;
   localparam int NSRC     = USERIO_W + 6;  // aux, nrst, io1-4, user io

   logic                             clk_usb;
   logic                             reset;
   logic [7:0]                       reg_address_i;
   logic [cw_reg_pkg::BYTECNT_W-1:0] reg_bytecnt_i;
   logic [7:0]                       reg_datai_i;
   logic                             reg_write_i;
   logic                             reg_read_i;
   logic                             trigger_aux_i;
   logic                             trigger_nrst_i;
   logic [3:0]                       trigger_io_i;
   logic [USERIO_W-1:0]              userio_d_i;
   logic                             trigger_advio_i;
   logic                             trigger_sad_i;
   logic                             trigger_decodedio_i;
   logic                             trigger_trace_i;
   logic                             trigger_adc_i;
   logic                             trigger_edge_i;
   logic                             trace_exists_i;
   logic                             la_exists_i;
   logic [7:0]                       reg_datao_o;
   logic                             trigger_ext_o;
   logic                             trigger_capture_o;
   logic                             decodeio_active_o;
   logic                             sad_active_o;
   logic                             edge_trigger_active_o;
   logic                             targetpower_off_o;
   logic                             enable_avrprog_o;
   logic                             enable_output_nrst_o;
   logic                             output_nrst_o;
   logic                             enable_output_pdid_o;
   logic                             output_pdid_o;
   logic                             enable_output_pdic_o;
   logic                             output_pdic_o;

   logic [15:0] trigsrc_sh;  // tb copy of the trigger-source register
   integer      seed = 32'h4231;
   int          errors;      // mismatches in the running test
   int          total_errors;
   int          tests_run;
   int          tests_failed;

   cw_reg_top #(.USERIO_W(USERIO_W)) DUT (.*);

   initial begin
      clk_usb = 1'b0;
      forever #4 clk_usb = ~clk_usb;  // 125 MHz
   end

   // OR/AND/NAND merge of the enabled external trigger sources
   function automatic logic ext_rule(input logic [15:0] tsrc, input logic [NSRC-1:0] src);
      logic [NSRC-1:0] mask;
      logic            any_hi;
      logic            all_hi;
      mask   = {tsrc[8 +: USERIO_W], tsrc[5:0]};
      any_hi = 1'b0;
      all_hi = 1'b1;  // nothing enabled counts as all high
      for (int i = 0; i < NSRC; i++) begin
         if (mask[i] && src[i]) any_hi = 1'b1;
         if (mask[i] && !src[i]) all_hi = 1'b0;
      end
      case (tsrc[7:6])
         cw_reg_pkg::TRIG_OR:   return any_hi;
         cw_reg_pkg::TRIG_AND:  return all_hi;
         cw_reg_pkg::TRIG_NAND: return ~all_hi;
         default:               return 1'b0;
      endcase
   endfunction

   // mods bit order is advio, sad, decodedio, trace, adc, edge
   function automatic logic capture_rule(input logic [2:0] mode, input logic ext,
                                         input logic [5:0] mods);
      if (mode == 3'd0) return ext;
      if (mode == 3'd7) return 1'b0;
      return mods[mode - 3'd1];
   endfunction

   task automatic check_val(input string sig, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, sig, got, exp);
         errors++;
      end
   endtask

   // one write strobe with the register update on the rising edge in between
   task automatic write_reg(input logic [7:0] addr, input logic [6:0] cnt,
                            input logic [7:0] data);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_bytecnt_i = cnt;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      @(negedge clk_usb);
      reg_write_i   = 1'b0;
      if (addr == cw_reg_pkg::ADDR_TRIGSRC && cnt < 7'd2) trigsrc_sh[cnt[0]*8 +: 8] = data;
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [6:0] cnt,
                             input logic [7:0] exp);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_bytecnt_i = cnt;
      reg_read_i    = 1'b1;
      #1 check_val("reg_datao_o", reg_datao_o, exp);
      reg_read_i    = 1'b0;
   endtask

   task automatic read_idle_check(input logic [7:0] addr, input logic [6:0] cnt);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_bytecnt_i = cnt;
      reg_read_i    = 1'b0;  // data bus must stay at 0
      #1 check_val("reg_datao_o", reg_datao_o, 8'h00);
   endtask

   task automatic apply_triggers(input logic [NSRC-1:0] src, input logic [5:0] mods);
      @(negedge clk_usb);
      {userio_d_i, trigger_io_i, trigger_nrst_i, trigger_aux_i} = src;
      {trigger_edge_i, trigger_adc_i, trigger_trace_i,
       trigger_decodedio_i, trigger_sad_i, trigger_advio_i} = mods;
      #1;  // combinational path settles
   endtask

   // 4 masks x 50 vectors with the first mask empty for the AND corner case
   task automatic combine_sweep(input logic [1:0] mode);
      logic [31:0]     rnd;
      logic [NSRC-1:0] src;
      write_reg(cw_reg_pkg::ADDR_TRIGMOD, 7'd0, 8'h00);
      for (int m = 0; m < 4; m++) begin
         rnd = (m == 0) ? 32'd0 : $random(seed);
         write_reg(cw_reg_pkg::ADDR_TRIGSRC, 7'd0, {mode, rnd[5:0]});
         write_reg(cw_reg_pkg::ADDR_TRIGSRC, 7'd1, rnd[13:6]);
         for (int v = 0; v < 50; v++) begin
            rnd = $random(seed);
            src = rnd[NSRC-1:0];
            apply_triggers(src, rnd[21:16]);
            check_val("trigger_ext_o", 8'(trigger_ext_o), 8'(ext_rule(trigsrc_sh, src)));
         end
      end
   endtask

   task automatic mode_sweep();
      logic [31:0]     rnd;
      logic [NSRC-1:0] src;
      logic            ext;
      for (int m = 0; m < 8; m++) begin
         write_reg(cw_reg_pkg::ADDR_TRIGMOD, 7'd0, 8'(m));
         for (int v = 0; v < 12; v++) begin
            rnd = $random(seed);
            src = rnd[NSRC-1:0];
            ext = ext_rule(trigsrc_sh, src);
            apply_triggers(src, rnd[21:16]);
            check_val("trigger_capture_o", 8'(trigger_capture_o),
                      8'(capture_rule(3'(m), ext, rnd[21:16])));
            check_val("active flags {decodeio,sad,edge}",
                      8'({decodeio_active_o, sad_active_o, edge_trigger_active_o}),
                      8'({m == 3, m == 2, m == 6}));
         end
      end
   endtask

   task automatic soft_start_run(input logic [15:0] period, input logic [15:0] off1,
                                 input logic [15:0] off2, input logic [7:0] c1,
                                 input logic [7:0] c2);
      logic [63:0] word;
      int          limit;
      int          low_run;
      int          cyc;
      bit          seen_hi;
      bit          seen_lo;
      word = {off2, off1, period, c2, c1};  // byte 0 is cycles1
      for (int b = 0; b < 8; b++) write_reg(cw_reg_pkg::ADDR_SOFTPOWER, 7'(b), word[8*b +: 8]);
      write_reg(cw_reg_pkg::ADDR_IOROUTE, 7'd5, 8'h02);  // power off with slow start
      check_val("targetpower_off_o", 8'(targetpower_off_o), 8'h01);
      write_reg(cw_reg_pkg::ADDR_IOROUTE, 7'd5, 8'h00);  // release starts the ramp
      seen_hi = 1'b0;
      seen_lo = 1'b0;
      for (cyc = 0; cyc < 2 * (int'(period) + 1); cyc++) begin
         @(negedge clk_usb);
         if (targetpower_off_o) seen_hi = 1'b1;
         else seen_lo = 1'b1;
      end
      if (!(seen_hi && seen_lo)) begin
         $display("ERROR: targetpower_off_o did not toggle in the first two PWM periods");
         errors++;
      end
      limit   = (int'(c1) + int'(c2) + 2) * (int'(period) + 1);
      low_run = 0;
      cyc     = 0;
      while (low_run < 50 && cyc < limit + 50) begin  // settle and then 50 low cycles in a row
         @(negedge clk_usb);
         low_run = targetpower_off_o ? 0 : low_run + 1;
         cyc++;
      end
      if (low_run < 50) begin
         $display("ERROR: targetpower_off_o did not settle low within %0d cycles", limit);
         errors++;
      end
   endtask

   task automatic fast_start_run();
      write_reg(cw_reg_pkg::ADDR_IOROUTE, 7'd5, 8'h04);
      check_val("targetpower_off_o", 8'(targetpower_off_o), 8'h00);
      write_reg(cw_reg_pkg::ADDR_IOROUTE, 7'd5, 8'h06);
      check_val("targetpower_off_o", 8'(targetpower_off_o), 8'h01);
      write_reg(cw_reg_pkg::ADDR_IOROUTE, 7'd5, 8'h04);  // no ramp with fast start
      check_val("targetpower_off_o", 8'(targetpower_off_o), 8'h00);
      // the release arms the sequencer one edge later, power must stay on anyway
      for (int c = 0; c < 20; c++) begin
         @(negedge clk_usb);
         check_val("targetpower_off_o", 8'(targetpower_off_o), 8'h00);
      end
   endtask

   initial begin
      string       line;
      string       name;
      logic [7:0]  op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [31:0] f5;
      int          fd;
      int          n;
      int          nl;
      reset          = 1'b1;
      reg_address_i  = 8'h00;
      reg_bytecnt_i  = '0;
      reg_datai_i    = 8'h00;
      reg_write_i    = 1'b0;
      reg_read_i     = 1'b0;
      trace_exists_i = 1'b1;  // components byte reads 02
      la_exists_i    = 1'b0;
      userio_d_i          = '0;
      trigger_io_i        = 4'h0;
      trigger_nrst_i      = 1'b0;
      trigger_aux_i       = 1'b0;
      trigger_advio_i     = 1'b0;
      trigger_sad_i       = 1'b0;
      trigger_decodedio_i = 1'b0;
      trigger_trace_i     = 1'b0;
      trigger_adc_i       = 1'b0;
      trigger_edge_i      = 1'b0;
      trigsrc_sh     = cw_reg_pkg::TRIGSRC_RST;
      errors         = 0;
      total_errors   = 0;
      tests_run      = 0;
      tests_failed   = 0;
      repeat (5) @(negedge clk_usb);
      reset = 1'b0;
      fd = $fopen("dv/cw_reg_testdata.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open dv/cw_reg_testdata.txt");
         $display("Simulation finished: FAIL");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5);
               case (op)
                  "W": write_reg(f1[7:0], f2[6:0], f3[7:0]);
                  "R": read_check(f1[7:0], f2[6:0], f3[7:0]);
                  "Z": read_idle_check(f1[7:0], f2[6:0]);
                  "I": begin
                     @(negedge clk_usb);
                     check_val("{targetpower_off,avrprog,nrst_en,nrst,pdid_en,pdid,pdic_en,pdic}",
                               {targetpower_off_o, enable_avrprog_o, enable_output_nrst_o,
                                output_nrst_o, enable_output_pdid_o, output_pdid_o,
                                enable_output_pdic_o, output_pdic_o}, f1[7:0]);
                  end
                  "V": begin
                     apply_triggers(f1[NSRC-1:0], f2[5:0]);
                     check_val("trigger_ext_o", 8'(trigger_ext_o), f3[7:0]);
                     check_val("trigger_capture_o", 8'(trigger_capture_o), f4[7:0]);
                  end
                  "C": combine_sweep(f1[1:0]);
                  "S": mode_sweep();
                  "P": soft_start_run(f1[15:0], f2[15:0], f3[15:0], f4[7:0], f5[7:0]);
                  "F": fast_start_run();
                  "E": begin
                     nl   = (line[line.len()-1] == "\n") ? 2 : 1;
                     name = line.substr(2, line.len() - nl);
                     tests_run++;
                     if (errors != 0) tests_failed++;
                     $display("test %s: %s (%0d errors)", name,
                              (errors == 0) ? "ok" : "FAILED", errors);
                     total_errors += errors;
                     errors = 0;
                  end
                  default: begin
                     $display("ERROR: unknown opcode '%c' in test data", op);
                     errors++;
                  end
               endcase
            end
         end
         $fclose(fd);
         total_errors += errors;  // checks after the last test marker
         $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                  tests_run - tests_failed, tests_failed, total_errors);
         if (total_errors == 0 && tests_run > 0) begin
            $display("Simulation finished: PASS");
         end else begin
            $display("Simulation finished: FAIL");
         end
         $finish;
      end
   end

endmodule

// File: dv/cw_reg_testdata.txt
# op: W addr cnt data | R addr cnt expect | Z addr cnt | I outputs | V src mods ext cap
# op: C combine mode | S | P period off1 off2 cycles1 cycles2 | F | E test name (hex fields)
R 26 00 03
R 27 00 20
R 27 01 00
R 28 00 00
R 37 00 01
R 37 01 02
R 37 05 00
R 3E 00 02
R 3F 00 23
R 3F 01 00
R 3F 02 D0
R 3F 03 07
R 3F 04 CB
R 3F 05 07
R 10 00 00
Z 26 00
I 00
E reset_values
W 27 01 A5
R 27 01 A5
R 27 00 20
W 27 01 00
W 37 05 01
W 37 06 15
I 6A
R 37 06 15
W 37 06 3F
I 7F
W 3F 07 5A
R 3F 07 5A
R 3F 06 00
W 37 06 00
W 37 05 00
I 00
E byte_access
V 0020 00 1 1
V 3FDF 00 0 0
W 27 00 4C
V 000C 00 1 1
V 0004 00 0 0
W 28 00 01
V 0000 01 0 1
C 0
C 1
C 2
E ext_combine
S
E mode_select
P 9 5 2 2 2
F
E soft_start

// File: verilog.f
verilog/cw_reg_pkg.sv
verilog/cw_reg_file.sv
verilog/trigger_combine.sv
verilog/target_power_softstart.sv
verilog/cw_reg_top.sv
dv/cw_reg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module cw_reg_tb -o cw_reg_sim
./obj_dir/cw_reg_sim | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
   echo "run_sim: passed"
   exit 0
fi
echo "run_sim: failed"
exit 1
